//--- rtl/eeprom_pkg.sv
package eeprom_pkg;

  localparam int ADDR_W = 11;
  localparam int DATA_W = 8;

  // device type code, top nibble of every control byte
  localparam logic [3:0] DEV_CODE = 4'b1010;

  // clocks per quarter of an scl period
  localparam int SCL_QTR = 4;
  localparam int QTR_W   = $clog2(SCL_QTR);

  localparam int QUEUE_DEPTH = 4;
  localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
  localparam int QCNT_W      = $clog2(QUEUE_DEPTH + 1);

  typedef struct packed {
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } eeprom_cmd_t;

  // data is the read byte on a read, the written byte on a write
  typedef struct packed {
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic              nack;
  } eeprom_rsp_t;

  typedef enum logic [1:0] {
    LINE_START,
    LINE_STOP,
    LINE_TX,
    LINE_RX
  } line_kind_e;

  typedef struct packed {
    line_kind_e        kind;
    logic [DATA_W-1:0] data;
    logic              last;  // answer a received byte with nack
  } line_op_t;

endpackage

//--- rtl/cmd_queue.sv
`timescale 1ns/1ps
module cmd_queue (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    push,
  input  eeprom_pkg::eeprom_cmd_t push_cmd,
  input  logic                    pop,
  output eeprom_pkg::eeprom_cmd_t head,
  output logic                    not_empty,
  output logic                    dropped
);
  import eeprom_pkg::*;

  eeprom_cmd_t       mem [QUEUE_DEPTH];
  logic [QPTR_W-1:0] wr_ptr;
  logic [QPTR_W-1:0] rd_ptr;
  logic [QCNT_W-1:0] count;
  logic              full;
  logic              do_push;
  logic              do_pop;

  function automatic logic [QPTR_W-1:0] ptr_inc(input logic [QPTR_W-1:0] p);
    return (p == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full      = (count == QCNT_W'(QUEUE_DEPTH));
  assign not_empty = (count != '0);
  assign do_push   = push && !full;  // a full queue discards the push
  assign do_pop    = pop && not_empty;
  assign head      = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= push_cmd;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      dropped <= 1'b0;
    end else begin
      dropped <= push && full;
      if (do_push) wr_ptr <= ptr_inc(wr_ptr);
      if (do_pop) rd_ptr <= ptr_inc(rd_ptr);
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- rtl/i2c_line_engine.sv
`timescale 1ns/1ps
module i2c_line_engine (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 op_valid,
  input  eeprom_pkg::line_op_t op,
  output logic                 op_done,
  output logic [7:0]           rx_byte,
  output logic                 ack_ok,
  output logic                 scl,
  output logic                 sda_oe,
  input  logic                 sda_in
);
  import eeprom_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_START,
    ST_STOP,
    ST_TX,
    ST_RX
  } eng_state_e;

  eng_state_e       state;
  logic [QTR_W-1:0] tick;     // clocks within a quarter
  logic [1:0]       phase;    // quarter within a bit
  logic [3:0]       bit_idx;  // 8 is the acknowledge bit
  logic [7:0]       sh;
  logic             last;
  logic             qtr_end;
  logic             ack_bit;
  logic             op_end;
  logic             scl_nxt;
  logic             oe_nxt;

  assign qtr_end = (tick == QTR_W'(SCL_QTR - 1));
  assign ack_bit = (bit_idx == 4'd8);
  assign op_end  = qtr_end && (phase == 2'd3) &&
                   ((state == ST_START) || (state == ST_STOP) || ack_bit);
  assign rx_byte = sh;

  // line levels for the current quarter, registered one clock later
  always_comb begin
    scl_nxt = phase[0] ^ phase[1];  // high in quarters 1 and 2
    oe_nxt  = 1'b0;
    case (state)
      ST_START: oe_nxt = phase[1];  // sda falls while scl high
      ST_STOP: begin
        scl_nxt = (phase != 2'd0);
        oe_nxt  = !phase[1];        // sda rises while scl high
      end
      ST_TX:   oe_nxt = !ack_bit && !sh[7];
      ST_RX:   oe_nxt = ack_bit && !last;
      default: begin
        scl_nxt = scl;  // hold the line between ops
        oe_nxt  = sda_oe;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= ST_IDLE;
      tick    <= '0;
      phase   <= '0;
      bit_idx <= '0;
      op_done <= 1'b0;
      ack_ok  <= 1'b0;
      scl     <= 1'b1;
      sda_oe  <= 1'b0;
    end else begin
      op_done <= 1'b0;
      scl     <= scl_nxt;
      sda_oe  <= oe_nxt;
      if (state == ST_IDLE) begin
        if (op_valid) begin
          case (op.kind)
            LINE_START: state <= ST_START;
            LINE_STOP:  state <= ST_STOP;
            LINE_TX:    state <= ST_TX;
            default:    state <= ST_RX;
          endcase
          tick    <= '0;
          phase   <= '0;
          bit_idx <= '0;
          ack_ok  <= 1'b1;
        end
      end else begin
        tick <= qtr_end ? '0 : tick + 1'b1;
        if (qtr_end) begin
          phase <= phase + 1'b1;
          // ack sampled mid-high on the ninth bit
          if (phase == 2'd1 && state == ST_TX && ack_bit) ack_ok <= !sda_in;
          if (phase == 2'd3) bit_idx <= bit_idx + 1'b1;
        end
        if (op_end) begin
          state   <= ST_IDLE;
          op_done <= 1'b1;
        end
      end
    end
  end

  // shift register, msb first both ways
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && op_valid) begin
      sh   <= op.data;
      last <= op.last;
    end else if (qtr_end && !ack_bit) begin
      if (state == ST_RX && phase == 2'd1) sh <= {sh[6:0], sda_in};
      if (state == ST_TX && phase == 2'd3) sh <= {sh[6:0], 1'b0};
    end
  end

endmodule

//--- rtl/eeprom_wr.sv
`timescale 1ns/1ps
module eeprom_wr (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    q_valid,
  input  eeprom_pkg::eeprom_cmd_t q_cmd,
  output logic                    q_pop,
  output logic                    op_valid,
  output eeprom_pkg::line_op_t    op,
  input  logic                    op_done,
  input  logic [7:0]              rx_byte,
  input  logic                    ack_ok,
  output logic                    rsp_valid,
  output eeprom_pkg::eeprom_rsp_t rsp
);
  import eeprom_pkg::*;

  typedef enum logic [9:0] {
    ST_IDLE        = 10'b00_0000_0001,
    ST_WRITE_START = 10'b00_0000_0010,
    ST_CTRL_WRITE  = 10'b00_0000_0100,
    ST_ADDR_WRITE  = 10'b00_0000_1000,
    ST_DATA_WRITE  = 10'b00_0001_0000,
    ST_READ_START  = 10'b00_0010_0000,
    ST_CTRL_READ   = 10'b00_0100_0000,
    ST_DATA_READ   = 10'b00_1000_0000,
    ST_STOP        = 10'b01_0000_0000,
    ST_RESPOND     = 10'b10_0000_0000
  } wr_state_e;

  wr_state_e         state;
  logic              pending;  // op issued, waiting for op_done
  logic              op_state;
  logic              nack;
  eeprom_cmd_t       cmd_q;
  logic [DATA_W-1:0] data_q;
  logic [DATA_W-1:0] ctrl_byte;
  line_op_t          op_cur;

  assign q_pop     = (state == ST_IDLE) && q_valid;
  assign rsp_valid = (state == ST_RESPOND);
  assign rsp       = '{write: cmd_q.write, addr: cmd_q.addr, data: data_q, nack: nack};
  assign op_state  = (state != ST_IDLE) && (state != ST_RESPOND);
  // block select rides in the control byte, r/w in bit 0
  assign ctrl_byte = {DEV_CODE, cmd_q.addr[ADDR_W-1:DATA_W], (state == ST_CTRL_READ)};

  always_comb begin
    op_cur = '{kind: LINE_STOP, data: ctrl_byte, last: 1'b0};
    case (state)
      ST_WRITE_START, ST_READ_START: op_cur.kind = LINE_START;
      ST_CTRL_WRITE, ST_CTRL_READ:   op_cur.kind = LINE_TX;
      ST_ADDR_WRITE: begin
        op_cur.kind = LINE_TX;
        op_cur.data = cmd_q.addr[DATA_W-1:0];
      end
      ST_DATA_WRITE: begin
        op_cur.kind = LINE_TX;
        op_cur.data = cmd_q.data;
      end
      ST_DATA_READ: begin
        op_cur.kind = LINE_RX;
        op_cur.last = 1'b1;  // single byte, so nack it
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ST_IDLE;
      pending  <= 1'b0;
      op_valid <= 1'b0;
    end else begin
      op_valid <= 1'b0;
      if (state == ST_IDLE) begin
        if (q_valid) state <= ST_WRITE_START;
      end else if (state == ST_RESPOND) begin
        state <= ST_IDLE;
      end else if (!pending) begin
        op_valid <= 1'b1;
        pending  <= 1'b1;
      end else if (op_done) begin
        pending <= 1'b0;
        case (state)
          ST_WRITE_START: state <= ST_CTRL_WRITE;
          ST_CTRL_WRITE:  state <= ack_ok ? ST_ADDR_WRITE : ST_STOP;
          ST_ADDR_WRITE: begin
            if (!ack_ok) state <= ST_STOP;
            else if (cmd_q.write) state <= ST_DATA_WRITE;
            else state <= ST_READ_START;
          end
          ST_DATA_WRITE:  state <= ST_STOP;
          ST_READ_START:  state <= ST_CTRL_READ;
          ST_CTRL_READ:   state <= ack_ok ? ST_DATA_READ : ST_STOP;
          ST_DATA_READ:   state <= ST_STOP;
          default:        state <= ST_RESPOND;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (op_state && !pending) op <= op_cur;
    if (q_pop) begin
      cmd_q  <= q_cmd;
      data_q <= q_cmd.data;
      nack   <= 1'b0;
    end else if (pending && op_done) begin
      if (state == ST_DATA_READ) data_q <= rx_byte;
      else if (op_cur.kind == LINE_TX) nack <= nack | !ack_ok;  // sticky over the command
    end
  end

endmodule

//--- rtl/eeprom_top.sv
`timescale 1ns/1ps
module eeprom_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    cmd_valid,
  input  eeprom_pkg::eeprom_cmd_t cmd,
  output logic                    cmd_drop,
  output logic                    rsp_valid,
  output eeprom_pkg::eeprom_rsp_t rsp,
  output logic                    scl,
  inout  wire                     sda
);
  import eeprom_pkg::*;

  eeprom_cmd_t q_cmd;
  logic        q_valid;
  logic        q_pop;
  logic        q_dropped;
  line_op_t    op;
  logic        op_valid;
  logic        op_done;
  logic [7:0]  rx_byte;
  logic        ack_ok;
  logic        sda_oe;
  logic        sda_in;

  // open drain, high level from the external pull-up
  assign sda    = sda_oe ? 1'b0 : 1'bz;
  assign sda_in = sda;

  always_ff @(posedge clk) begin
    if (rst) cmd_drop <= 1'b0;
    else cmd_drop <= q_dropped;  // host sees the drop one clock after the queue
  end

  cmd_queue u_cmd_queue (
    .clk(clk), .rst(rst), .push(cmd_valid), .push_cmd(cmd), .pop(q_pop),
    .head(q_cmd), .not_empty(q_valid), .dropped(q_dropped)
  );

  eeprom_wr u_eeprom_wr (
    .clk(clk), .rst(rst), .q_valid(q_valid), .q_cmd(q_cmd), .q_pop(q_pop),
    .op_valid(op_valid), .op(op), .op_done(op_done), .rx_byte(rx_byte),
    .ack_ok(ack_ok), .rsp_valid(rsp_valid), .rsp(rsp)
  );

  i2c_line_engine u_line_engine (
    .clk(clk), .rst(rst), .op_valid(op_valid), .op(op), .op_done(op_done),
    .rx_byte(rx_byte), .ack_ok(ack_ok), .scl(scl), .sda_oe(sda_oe), .sda_in(sda_in)
  );

endmodule

//--- verif/eeprom_model.sv
`timescale 1ns/1ps
module eeprom_model (
  input logic clk,
  input logic ack_en,  // low makes the device ignore its control byte
  input logic scl,
  inout wire  sda
);
  import eeprom_pkg::*;

  typedef enum logic [2:0] {M_IDLE, M_CTRL, M_ADDR, M_DATA, M_RSTART, M_READ} model_state_e;

  logic [7:0]        mem [2**ADDR_W];
  model_state_e      state    = M_IDLE;
  logic [ADDR_W-1:0] addr     = '0;  // internal address counter
  logic [2:0]        blk      = '0;
  logic [7:0]        rx_sh    = '0;
  logic [7:0]        tx_sh    = '0;
  logic [3:0]        bit_cnt  = '0;
  logic              scl_q    = 1'b1;
  logic              sda_q    = 1'b1;
  logic              sda_low  = 1'b0;
  logic              host_ack = 1'b0;

  assign sda = sda_low ? 1'b0 : 1'bz;

  initial begin
    for (int i = 0; i < 2**ADDR_W; i++) mem[ADDR_W'(i)] <= 8'(i) ^ 8'(i >> 3) ^ 8'h5a;
  end

  // line sampled on the much faster system clock
  always @(posedge clk) begin
    scl_q <= scl;
    sda_q <= sda;
    if (scl && scl_q && sda_q && !sda) begin  // start
      state   <= M_CTRL;
      bit_cnt <= 4'hf;  // wraps to 0 on the scl fall that ends the start
      sda_low <= 1'b0;
    end else if (scl && scl_q && !sda_q && sda) begin  // stop
      state   <= M_IDLE;
      sda_low <= 1'b0;
    end else if (scl && !scl_q) begin
      if (bit_cnt < 4'd8) rx_sh <= {rx_sh[6:0], sda};
      else host_ack <= !sda;
    end else if (!scl && scl_q) begin
      if (bit_cnt == 4'd7) begin
        bit_cnt <= 4'd8;
        sda_low <= 1'b0;
        case (state)
          M_CTRL: begin
            if (ack_en && rx_sh[7:4] == DEV_CODE) begin
              blk     <= rx_sh[3:1];
              state   <= rx_sh[0] ? M_RSTART : M_ADDR;
              sda_low <= 1'b1;
            end else begin
              state <= M_IDLE;
            end
          end
          M_ADDR: begin
            addr    <= {blk, rx_sh};
            state   <= M_DATA;
            sda_low <= 1'b1;
          end
          M_DATA: begin
            mem[addr] <= rx_sh;
            addr      <= addr + 1'b1;
            sda_low   <= 1'b1;
          end
          default: ;
        endcase
      end else if (bit_cnt == 4'd8) begin  // ack slot done
        bit_cnt <= '0;
        sda_low <= 1'b0;
        if (state == M_RSTART || (state == M_READ && host_ack)) begin
          state   <= M_READ;
          tx_sh   <= mem[addr];
          sda_low <= !mem[addr][7];
          addr    <= addr + 1'b1;
        end else if (state == M_READ) begin
          state <= M_IDLE;  // host said nack
        end
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
        if (state == M_READ) begin
          tx_sh   <= {tx_sh[6:0], 1'b0};
          sda_low <= !tx_sh[6];
        end
      end
    end
  end

endmodule

//--- verif/eeprom_checker.sv
`timescale 1ns/1ps
module eeprom_checker (
  input logic                 clk,
  input logic                 rst,
  input logic                 op_valid,
  input eeprom_pkg::line_op_t op,
  input logic                 op_done,
  input logic                 scl,
  input logic                 sda_oe
);
  import eeprom_pkg::*;

  logic busy;  // from op_valid up to op_done

  always_ff @(posedge clk) begin
    if (rst) busy <= 1'b0;
    else if (op_valid) busy <= 1'b1;
    else if (op_done) busy <= 1'b0;
  end

  sda_moves_under_high_scl: assert property (@(posedge clk) disable iff (rst)
    (scl && $past(scl) && (sda_oe != $past(sda_oe))) |->
      (op.kind == LINE_START || op.kind == LINE_STOP))
    else $error("sda_oe changed while scl was high outside a start or stop");

  op_done_one_cycle: assert property (@(posedge clk) disable iff (rst)
    op_done |=> !op_done)
    else $error("op_done held high for two cycles");

  no_op_while_busy: assert property (@(posedge clk) disable iff (rst)
    op_valid |-> !busy)
    else $error("op_valid arrived while an operation was in progress");

endmodule

//--- verif/eeprom_tb.sv
`timescale 1ns/1ps
module eeprom_tb;
  import eeprom_pkg::*;

  // a read: 3 start/stop conditions and 4 bytes of 9 bits, plus op overhead
  localparam int CMD_CYCLES = (3 + 4 * 9) * 4 * SCL_QTR + 64;
  localparam int RSP_LIMIT  = 3 * CMD_CYCLES;
  localparam int TEST_CMDS  = 20;
  localparam int RUN_LIMIT  = TEST_CMDS * CMD_CYCLES + 1000;

  logic              clk;
  logic              rst;
  logic              cmd_valid;
  eeprom_cmd_t       cmd;
  logic              cmd_drop;
  logic              rsp_valid;
  eeprom_rsp_t       rsp;
  logic              scl;
  wire               sda;
  logic              model_ack;
  logic [31:0]       seed   = 32'h4e7e_8b7b;
  int                cycles = 0;
  int                drops  = 0;
  eeprom_rsp_t       got_q[$];
  eeprom_rsp_t       exp_q[$];
  logic [7:0]        sb_mem [2**ADDR_W];  // expected device contents
  logic [ADDR_W-1:0] burst_addr[$];

  pullup (sda);

  eeprom_top dut0 (
    .clk(clk), .rst(rst), .cmd_valid(cmd_valid), .cmd(cmd), .cmd_drop(cmd_drop),
    .rsp_valid(rsp_valid), .rsp(rsp), .scl(scl), .sda(sda)
  );

  eeprom_model model0 (.clk(clk), .ack_en(model_ack), .scl(scl), .sda(sda));

  bind i2c_line_engine eeprom_checker chk0 (
    .clk(clk), .rst(rst), .op_valid(op_valid), .op(op), .op_done(op_done),
    .scl(scl), .sda_oe(sda_oe)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(negedge clk) begin
    if (rsp_valid) got_q.push_back(rsp);
    if (cmd_drop) drops++;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > RUN_LIMIT) fail_run("run went past its cycle limit");
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) fail_run($sformatf("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  // one strobe, expected response queued when the command will be taken
  task automatic issue(input logic wr, input logic [ADDR_W-1:0] a, input logic [7:0] d,
                       input bit accepted);
    eeprom_rsp_t e;
    @(negedge clk);
    cmd_valid = 1'b1;
    cmd = '{write: wr, addr: a, data: d};
    if (accepted) begin
      if (wr) sb_mem[a] = d;
      e = '{write: wr, addr: a, data: sb_mem[a], nack: 1'b0};
      exp_q.push_back(e);
    end
  endtask

  task automatic idle_bus();
    @(negedge clk);
    cmd_valid = 1'b0;
  endtask

  task automatic wait_rsp();
    int n;
    n = 0;
    while (got_q.size() == 0) begin
      @(posedge clk);
      n++;
      if (n > RSP_LIMIT) fail_run("no response from the DUT within three command lengths");
    end
  endtask

  task automatic drain_rsp();
    eeprom_rsp_t g;
    eeprom_rsp_t e;
    while (exp_q.size() != 0) begin
      wait_rsp();
      g = got_q.pop_front();
      e = exp_q.pop_front();
      check_eq("rsp.write", 32'(g.write), 32'(e.write));
      check_eq("rsp.addr", 32'(g.addr), 32'(e.addr));
      check_eq("rsp.data", 32'(g.data), 32'(e.data));
      check_eq("rsp.nack", 32'(g.nack), 32'(e.nack));
    end
  endtask

  // back-to-back: writes first, then reads of the written addresses
  task automatic run_burst(input int n);
    int nw;
    nw = (n + 1) / 2;
    burst_addr.delete();
    for (int i = 0; i < n; i++) begin
      if (i < nw) begin
        burst_addr.push_back(ADDR_W'(next_rand() >> 4));
        issue(1'b1, burst_addr[i], 8'(next_rand() >> 16), 1'b1);
      end else begin
        issue(1'b0, burst_addr[i - nw], 8'h00, 1'b1);
      end
    end
  endtask

  task automatic test_write_read();
    logic [ADDR_W-1:0] a;
    a = ADDR_W'(next_rand() >> 3);
    issue(1'b1, a, 8'(next_rand() >> 8), 1'b1);
    issue(1'b0, a, 8'h00, 1'b1);
    idle_bus();
    drain_rsp();
  endtask

  task automatic test_block_select();
    logic [ADDR_W-1:0] addrs [3];
    logic [7:0]        d;
    addrs = '{11'h012, 11'h112, 11'h712};  // same low byte, blocks 0, 1, 7
    d = 8'(next_rand() >> 12);
    foreach (addrs[i]) issue(1'b1, addrs[i], d + 8'(i * 37), 1'b1);
    idle_bus();
    drain_rsp();
    foreach (addrs[i]) issue(1'b0, addrs[i], 8'h00, 1'b1);
    idle_bus();
    drain_rsp();
  endtask

  task automatic test_queued_burst();
    int drops0;
    drops0 = drops;
    run_burst(QUEUE_DEPTH + 1);
    idle_bus();
    drain_rsp();
    check_eq("cmd_drop count", 32'(drops - drops0), 32'd0);
  endtask

  task automatic test_overflow();
    int drops0;
    drops0 = drops;
    run_burst(QUEUE_DEPTH + 1);
    issue(1'b1, burst_addr[0], ~sb_mem[burst_addr[0]], 1'b0);  // meets a full queue
    idle_bus();
    drain_rsp();
    check_eq("cmd_drop count", 32'(drops - drops0), 32'd1);
    issue(1'b0, burst_addr[0], 8'h00, 1'b1);
    idle_bus();
    drain_rsp();
  endtask

  task automatic test_no_device();
    eeprom_rsp_t       g;
    logic [ADDR_W-1:0] a;
    a = ADDR_W'(next_rand() >> 7);
    model_ack = 1'b0;
    issue(1'b0, a, 8'h00, 1'b0);  // no scoreboard entry, checked here
    idle_bus();
    wait_rsp();
    g = got_q.pop_front();
    check_eq("rsp.nack", 32'(g.nack), 32'd1);
    check_eq("rsp.write", 32'(g.write), 32'd0);
    check_eq("rsp.addr", 32'(g.addr), 32'(a));
    @(negedge clk);
    check_eq("scl", 32'(scl), 32'd1);
    check_eq("sda", 32'(sda), 32'd1);
    model_ack = 1'b1;
  endtask

  initial begin
    rst = 1'b1;
    cmd_valid = 1'b0;
    cmd = '0;
    model_ack = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_eq("rsp_valid", 32'(rsp_valid), 32'd0);
    check_eq("cmd_drop", 32'(cmd_drop), 32'd0);
    check_eq("scl", 32'(scl), 32'd1);
    test_write_read();
    test_block_select();
    test_queued_burst();
    test_overflow();
    test_no_device();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

//--- verilog.f
rtl/eeprom_pkg.sv
rtl/cmd_queue.sv
rtl/i2c_line_engine.sv
rtl/eeprom_wr.sv
rtl/eeprom_top.sv
verif/eeprom_model.sv
verif/eeprom_checker.sv
verif/eeprom_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= eeprom_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
